//--- traceDisasm.f
+incdir+.
rvIsaPkg.sv
traceLinePkg.sv
instDisasm.sv
lineBuilder.sv
charSerializer.sv
traceControl.sv
traceDisasm.sv
traceDisasm_properties.sv
tb_traceDisasm.sv

//--- tb_traceDisasm.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module tb_traceDisasm;
    import traceLinePkg::*;

    logic                  clk;
    logic                  reset;
    logic                  retire;
    retireRec              retireData;
    logic                  charValid;
    logic [7:0]            charData;
    logic                  lineDone;
    logic [`DROP_BITS-1:0] dropCount;

    int          cycleCnt = 0;
    int          charCount = 0;
    int          firstCycle;
    int          compared = 0;
    int          sentOk = 0;
    int          dropSent = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    traceLine    curLine;
    traceLine    gotLines [$];
    int          gotFirst [$];
    int          gotDone [$];
    int          gotCount [$];
    traceLine    expLines [$];
    int          expFirst [$];
    logic [31:0] words [$];

    traceDisasm u_traceDisasm (
        .clk        (clk),
        .reset      (reset),
        .retire     (retire),
        .retireData (retireData),
        .charValid  (charValid),
        .charData   (charData),
        .lineDone   (lineDone),
        .dropCount  (dropCount)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    function automatic string hexDigits(input logic [31:0] v, input int n);
        string      s;
        logic [3:0] nib;
        s = "";
        for (int i = n - 1; i >= 0; i--) begin
            nib = v[i*4 +: 4];
            if (nib < 4'd10) begin
                s = $sformatf("%s%c", s, 8'h30 + nib);
            end else begin
                s = $sformatf("%s%c", s, 8'h37 + nib);  // Uppercase letters.
            end
        end
        return s;
    endfunction

    function automatic string regStr(input logic [4:0] r);
        return {"x", hexDigits(r, 2)};
    endfunction

    function automatic string refText(input logic [31:0] w);
        string      m;
        string      ops;
        string      iImm;
        logic [2:0] f3;
        logic [6:0] f7;
        m    = "";
        ops  = "";
        f3   = w[14:12];
        f7   = w[31:25];
        iImm = {hexDigits(w[31:20], 3), "H"};
        if (w == 32'h30200073) return "mret";
        if (w == 32'h00000073) return "ecall";
        if (w == 32'h00000013) return "nop";
        if (w == 32'h00000000) return "stall";
        case (w[6:2])
            5'b01100: begin
                ops = {regStr(w[11:7]), ",", regStr(w[19:15]), ",", regStr(w[24:20])};
                case ({f7, f3})
                    {7'h00, 3'd0}: m = "add";
                    {7'h20, 3'd0}: m = "sub";
                    {7'h00, 3'd1}: m = "sll";
                    {7'h00, 3'd2}: m = "slt";
                    {7'h00, 3'd3}: m = "sltu";
                    {7'h00, 3'd4}: m = "xor";
                    {7'h00, 3'd5}: m = "srl";
                    {7'h20, 3'd5}: m = "sra";
                    {7'h00, 3'd6}: m = "or";
                    {7'h00, 3'd7}: m = "and";
                    default: m = "";
                endcase
            end
            5'b00100: begin
                ops = {regStr(w[11:7]), ",", regStr(w[19:15]), ",", iImm};
                case (f3)
                    3'd0: m = "addi";
                    3'd2: m = "slti";
                    3'd3: m = "sltiu";
                    3'd4: m = "xori";
                    3'd6: m = "ori";
                    3'd7: m = "andi";
                    3'd1: if (f7 == 7'h00) m = "slli";
                    default: begin
                        if (f7 == 7'h00) m = "srli";
                        if (f7 == 7'h20) m = "srai";
                    end
                endcase
            end
            5'b00000: begin
                ops = {regStr(w[11:7]), ",", regStr(w[19:15]), ",", iImm};
                if (f3 == 3'd2) m = "lw";
            end
            5'b01000: begin
                ops = {regStr(w[19:15]), ",", regStr(w[24:20]), ",",
                       hexDigits({w[31:25], w[11:7]}, 3), "H"};
                if (f3 == 3'd2) m = "sw";
            end
            5'b11000: begin
                ops = {regStr(w[19:15]), ",", regStr(w[24:20]), ",",
                       hexDigits({w[31], w[7], w[30:25], w[11:8], 1'b0}, 4), "H"};
                case (f3)
                    3'd0: m = "beq";
                    3'd1: m = "bne";
                    3'd4: m = "blt";
                    3'd5: m = "bge";
                    3'd6: m = "bltu";
                    3'd7: m = "bgeu";
                    default: m = "";
                endcase
            end
            5'b11011: begin
                m   = "jal";
                ops = {regStr(w[11:7]), ",",
                       hexDigits({w[31], w[19:12], w[20], w[30:21], 1'b0}, 6), "H"};
            end
            5'b11001: begin
                ops = {regStr(w[11:7]), ",", regStr(w[19:15]), ",", iImm};
                if (f3 == 3'd0) m = "jalr";
            end
            5'b01101: begin
                m   = "lui";
                ops = {regStr(w[11:7]), ",", hexDigits(w[31:12], 5), "H"};
            end
            5'b11100: begin
                ops = {regStr(w[11:7]), ",", hexDigits(w[31:20], 3), ","};
                ops = f3[2] ? {ops, hexDigits(w[19:15], 2)} : {ops, regStr(w[19:15])};
                case (f3)
                    3'd1: m = "csrrw";
                    3'd2: m = "csrrs";
                    3'd3: m = "csrrc";
                    3'd5: m = "csrrwi";
                    3'd6: m = "csrrsi";
                    3'd7: m = "csrrci";
                    default: m = "";
                endcase
            end
            default: m = "";
        endcase
        if (m == "") return "illegal instruction";
        return {m, " ", ops};
    endfunction

    function automatic traceLine refLine(input logic [31:0] pc, input logic [31:0] w);
        string    s;
        string    txt;
        traceLine l;
        txt = refText(w);
        while (txt.len() < `INST_CHARS) begin
            txt = {txt, " "};
        end
        s = {hexDigits(pc, `PC_CHARS), ": ", txt, "\n"};
        l = '0;
        for (int i = 0; i < s.len() && i < `LINE_CHARS; i++) begin
            l[(`LINE_CHARS-1-i)*8 +: 8] = s[i];
        end
        return l;
    endfunction

    task automatic checkValue(input string name, input traceLine got, input traceLine exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERR %s got %0h exp %0h", name, got, exp);
        end
    endtask

    task automatic finishRun();
        errorCount += u_traceDisasm.u_properties.failCount;
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // Caller sits 1 ns after a rising edge.
    task automatic sendRetire(input logic [31:0] pc, input logic [31:0] w, input bit accept);
        retire     = 1'b1;
        retireData = {pc, w};
        if (accept) begin
            expLines.push_back(refLine(pc, w));
            expFirst.push_back(cycleCnt + 3);
            sentOk++;
        end else begin
            dropSent++;
        end
        @(posedge clk);
        #1;
        retire = 1'b0;
    endtask

    task automatic waitLines(input int target);
        int n;
        n = 0;
        while (compared < target && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (compared < target) begin
            errorCount++;
            $display("timeout: line %0d did not come out within 200 cycles", target);
            finishRun();
        end
    endtask

    // Collect characters where outputs are stable.
    always @(negedge clk) begin
        if (reset) begin
            charCount = 0;
        end else if (charValid) begin
            if (charCount == 0) begin
                firstCycle = cycleCnt;
            end
            curLine = {curLine[`LINE_CHARS*8-9:0], charData};
            charCount++;
            if (lineDone) begin
                gotLines.push_back(curLine);
                gotFirst.push_back(firstCycle);
                gotDone.push_back(cycleCnt);
                gotCount.push_back(charCount);
                charCount = 0;
            end
        end
    end

    always @(posedge clk) begin
        int first;
        if (gotLines.size() != 0) begin
            if (expLines.size() == 0) begin
                errorCount++;
                $display("a line came out with no accepted retire behind it");
                void'(gotLines.pop_front());
                void'(gotFirst.pop_front());
                void'(gotDone.pop_front());
                void'(gotCount.pop_front());
            end else begin
                first = expFirst.pop_front();
                checkValue("charData line", gotLines.pop_front(), expLines.pop_front());
                checkValue("first charValid cycle", gotFirst.pop_front(), first);
                checkValue("lineDone cycle", gotDone.pop_front(), first + `LINE_CHARS - 1);
                checkValue("charValid count", gotCount.pop_front(), `LINE_CHARS);
            end
            compared++;
        end
    end

    initial begin
        int          errBefore;
        int          start;
        logic [31:0] w;
        logic [4:0]  opList [9];
        opList = '{5'b00000, 5'b00100, 5'b01000, 5'b01100, 5'b01101,
                   5'b11000, 5'b11001, 5'b11011, 5'b11100};
        void'($urandom(32'h71c04dd7));
        reset      = 1'b1;
        retire     = 1'b0;
        retireData = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        errBefore = errorCount;
        words = '{{7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33}, {7'h20, 5'd31, 5'd17, 3'd0, 5'd10, 7'h33},
                  {7'h20, 5'd4, 5'd5, 3'd5, 5'd6, 7'h33}, {7'h00, 5'd9, 5'd8, 3'd3, 5'd7, 7'h33},
                  {12'h7FF, 5'd1, 3'd0, 5'd2, 7'h13}, {7'h20, 5'd7, 5'd3, 3'd5, 5'd4, 7'h13},
                  {7'h00, 5'd31, 5'd8, 3'd1, 5'd9, 7'h13}, {12'h800, 5'd11, 3'd3, 5'd12, 7'h13},
                  {12'h010, 5'd2, 3'd2, 5'd5, 7'h03}, {7'h7F, 5'd6, 5'd2, 3'd2, 5'h1F, 7'h23},
                  {1'b1, 6'h3F, 5'd2, 5'd1, 3'd0, 4'hF, 1'b1, 7'h63},
                  {1'b0, 6'h01, 5'd9, 5'd8, 3'd7, 4'h2, 1'b0, 7'h63},
                  {1'b1, 10'h3FF, 1'b0, 8'hA5, 5'd1, 7'h6F}, {12'h004, 5'd1, 3'd0, 5'd0, 7'h67},
                  {20'hABCDE, 5'd15, 7'h37}, {12'h300, 5'd5, 3'd1, 5'd6, 7'h73},
                  {12'hF14, 5'd0, 3'd2, 5'd10, 7'h73}, {12'h342, 5'd7, 3'd3, 5'd0, 7'h73},
                  {12'h305, 5'h1F, 3'd5, 5'd1, 7'h73}, {12'h344, 5'd8, 3'd6, 5'd2, 7'h73},
                  {12'hB00, 5'd3, 3'd7, 5'd4, 7'h73}};
        foreach (words[i]) begin
            sendRetire(32'hFEDC_0000 + i * 4, words[i], 1'b1);
            waitLines(sentOk);
        end
        $display("test directed forms: %0d lines, %0d errors", words.size(),
                 errorCount - errBefore);

        errBefore = errorCount;
        words = '{32'h30200073, 32'h00000073, 32'h00000013, 32'h00000000,
                  {1'b0, 6'h00, 5'd2, 5'd1, 3'd2, 4'h4, 1'b0, 7'h63},  // Bad branch funct3.
                  {7'h01, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33},               // Bad funct7.
                  32'h0000007F, 32'h00000017, {12'h000, 5'd1, 3'd4, 5'd2, 7'h73},
                  {12'h000, 5'd1, 3'd0, 5'd2, 7'h03}};
        foreach (words[i]) begin
            sendRetire(32'h0000_A5A0 + i * 4, words[i], 1'b1);
            waitLines(sentOk);
        end
        $display("test fixed texts: %0d lines, %0d errors", words.size(),
                 errorCount - errBefore);

        errBefore = errorCount;
        for (int i = 0; i < 200; i++) begin
            w = $urandom();
            if (i % 2 == 0) begin
                w[6:0] = {opList[$urandom_range(8, 0)], 2'b11};
            end
            start = cycleCnt;
            sendRetire($urandom(), w, 1'b1);
            waitLines(sentOk);
            while (cycleCnt < start + 40) begin
                @(posedge clk);
                #1;
            end
        end
        $display("test random retires: 200 lines, %0d errors", errorCount - errBefore);

        errBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            sendRetire(32'h4000_0100 + i * 16, {12'h123, 5'd4, 3'd4, 5'd5, 7'h13}, 1'b1);
            repeat (4) @(posedge clk);
            #1;
            for (int k = 0; k < 3; k++) begin
                sendRetire(32'hDEAD_0000 + k, 32'h00000013, 1'b0);
            end
            waitLines(sentOk);
        end
        checkValue("dropCount", dropCount, dropSent);
        $display("test dropped retires: 4 lines, %0d errors", errorCount - errBefore);

        repeat (5) @(posedge clk);
        if (expLines.size() != 0) begin
            errorCount++;
            $display("%0d expected lines never came out", expLines.size());
        end
        finishRun();
    end

endmodule

//--- traceDisasm_properties.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module traceDisasmProperties (
    input logic                  clk,
    input logic                  reset,
    input logic                  build,
    input logic                  charValid,
    input logic [7:0]            charData,
    input logic                  lineDone,
    input logic [`DROP_BITS-1:0] dropCount
);

    int failCount = 0;  // Read by the testbench at the end.

    quietAfterReset: assert property (@(posedge clk) reset |=> !charValid [*2])
        else begin
            failCount++;
            $error("charValid high within two cycles of reset");
        end

    doneOnNewline: assert property (@(posedge clk) disable iff (reset)
        lineDone |-> charValid && charData == 8'h0A)
        else begin
            failCount++;
            $error("lineDone without a newline character");
        end

    // Build follows an accepted retire by one cycle.
    noEarlyChar: assert property (@(posedge clk) disable iff (reset)
        build |-> !$past(charValid) && !charValid ##1 !charValid)
        else begin
            failCount++;
            $error("character within 3 cycles of an accepted retire");
        end

    dropNeverFalls: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> dropCount >= $past(dropCount))
        else begin
            failCount++;
            $error("dropCount decreased");
        end

endmodule

bind traceDisasm traceDisasmProperties u_properties (
    .clk       (clk),
    .reset     (reset),
    .build     (build),
    .charValid (charValid),
    .charData  (charData),
    .lineDone  (lineDone),
    .dropCount (dropCount)
);

//--- traceDisasm.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module traceDisasm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   retire,
    input  traceLinePkg::retireRec retireData,
    output logic                   charValid,
    output logic [7:0]             charData,
    output logic                   lineDone,
    output logic [`DROP_BITS-1:0]  dropCount
);
    import traceLinePkg::*;
    import rvIsaPkg::*;

    retireRec held;
    instText  text;
    traceLine line;
    logic     build;
    logic     load;
    logic     lastChar;

    traceControl u_traceControl (
        .clk        (clk),
        .reset      (reset),
        .retire     (retire),
        .retireData (retireData),
        .lastChar   (lastChar),
        .held       (held),
        .build      (build),
        .load       (load),
        .lineDone   (lineDone),
        .dropCount  (dropCount)
    );

    instDisasm u_instDisasm (
        .code (held.code),
        .text (text)
    );

    lineBuilder u_lineBuilder (
        .clk   (clk),
        .build (build),
        .pc    (held.pc),
        .text  (text),
        .line  (line)
    );

    charSerializer u_charSerializer (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .line      (line),
        .charValid (charValid),
        .charData  (charData),
        .lastChar  (lastChar)
    );

endmodule

//--- traceControl.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module traceControl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   retire,
    input  traceLinePkg::retireRec retireData,
    input  logic                   lastChar,
    output traceLinePkg::retireRec held,
    output logic                   build,
    output logic                   load,
    output logic                   lineDone,
    output logic [`DROP_BITS-1:0]  dropCount
);

    typedef enum logic [1:0] {
        IDLE,
        BUILD,
        SEND
    } ctlState;

    ctlState state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            load  <= 1'b0;
        end else begin
            load <= 1'b0;
            case (state)
                IDLE: begin
                    if (retire) begin
                        state <= BUILD;
                    end
                end
                BUILD: begin
                    state <= SEND;
                    load  <= 1'b1;  // Line register is valid now.
                end
                SEND: begin
                    if (lastChar) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && retire) begin
            held <= retireData;
        end
    end

    // Retires outside IDLE are lost, no back-pressure.
    always_ff @(posedge clk) begin
        if (reset) begin
            dropCount <= '0;
        end else if (retire && state != IDLE && dropCount != '1) begin
            dropCount <= dropCount + 1'b1;
        end
    end

    assign build    = state == BUILD;
    assign lineDone = lastChar;

endmodule

//--- charSerializer.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module charSerializer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  traceLinePkg::traceLine line,
    output logic                   charValid,
    output logic [7:0]             charData,
    output logic                   lastChar
);
    import traceLinePkg::*;

    localparam int cntBits = $clog2(`LINE_CHARS + 1);

    traceLine           shiftReg;
    logic [cntBits-1:0] remaining;  // Characters still to send.

    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= line;
        end else if (remaining != '0) begin
            shiftReg <= shiftReg << 8;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= cntBits'(`LINE_CHARS);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign charValid = remaining != '0;
    assign charData  = shiftReg[`LINE_CHARS*8-1 -: 8];
    assign lastChar  = remaining == cntBits'(1);  // The newline.

endmodule

//--- lineBuilder.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module lineBuilder (
    input  logic                   clk,
    input  logic                   build,
    input  logic [31:0]            pc,
    input  rvIsaPkg::instText      text,
    output traceLinePkg::traceLine line
);
    import rvIsaPkg::*;

    logic [`PC_CHARS*8-1:0] pcHex;

    always_comb begin
        for (int i = 0; i < `PC_CHARS; i++) begin
            pcHex[i*8 +: 8] = hexChar(pc[i*4 +: 4]);
        end
    end

    always_ff @(posedge clk) begin
        if (build) begin
            line <= {pcHex, ": ", text, 8'h0A};  // Newline closes the line.
        end
    end

endmodule

//--- instDisasm.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module instDisasm (
    input  rvIsaPkg::rvInstWord code,
    output rvIsaPkg::instText   text
);
    import rvIsaPkg::*;

    rvOpcode     op;
    regText      rdName;
    regText      rs1Name;
    regText      rs2Name;
    logic [47:0] iHex;
    logic [47:0] sHex;
    logic [47:0] bHex;
    logic [47:0] jHex;
    logic [47:0] uHex;
    logic [47:0] zHex;
    logic [12:0] bOffset;
    logic [20:0] jOffset;
    instText     mnem;
    instText     ops;
    logic        legal;

    function automatic regText regName(input logic [4:0] r);
        return {"x", hexChar({3'b000, r[4]}), hexChar(r[3:0])};
    endfunction

    // Right-aligned digits, low nibble last.
    function automatic logic [47:0] hexField(input logic [23:0] v, input int unsigned digits);
        hexField = '0;
        for (int i = 0; i < 6; i++) begin
            if (i < digits) begin
                hexField[i*8 +: 8] = hexChar(v[i*4 +: 4]);
            end
        end
    endfunction

    // Strings are right-aligned with zero bytes above.
    function automatic int unsigned textLen(input instText s);
        textLen = 0;
        for (int i = 0; i < `INST_CHARS; i++) begin
            if (s[i*8 +: 8] != 8'h00) begin
                textLen = i + 1;
            end
        end
    endfunction

    function automatic instText joinText(input instText head, input instText tail);
        return (head << (textLen(tail) * 8)) | tail;
    endfunction

    function automatic instText leftJust(input instText s);
        instText     pad;
        int unsigned n;
        pad = {`INST_CHARS{8'h20}};
        n   = textLen(s);
        return (s << ((`INST_CHARS - n) * 8)) | (pad >> (n * 8));
    endfunction

    always_comb begin
        op      = rvOpcode'(code.rType.opcode[6:2]);
        rdName  = regName(code.rType.rd);
        rs1Name = regName(code.rType.rs1);
        rs2Name = regName(code.rType.rs2);
        bOffset = {code.bType.imm12, code.bType.imm11, code.bType.imm10_5,
                   code.bType.imm4_1, 1'b0};
        jOffset = {code.jType.imm20, code.jType.imm19_12, code.jType.imm11,
                   code.jType.imm10_1, 1'b0};
        iHex    = hexField({12'h000, code.iType.imm}, 3);  // Also the CSR number.
        sHex    = hexField({12'h000, code.sType.immHi, code.sType.immLo}, 3);
        bHex    = hexField({11'h000, bOffset}, 4);
        jHex    = hexField({3'h0, jOffset}, 6);
        uHex    = hexField({4'h0, code.uType.imm}, 5);
        zHex    = hexField({19'h00000, code.iType.rs1}, 2);
        mnem    = '0;
        ops     = '0;
        legal   = 1'b1;
        if (code == 32'h30200073) begin
            text = leftJust("mret");
        end else if (code == 32'h00000073) begin
            text = leftJust("ecall");
        end else if (code == 32'h00000013) begin
            text = leftJust("nop");  // Pipeline bubble.
        end else if (code == 32'h00000000) begin
            text = leftJust("stall");
        end else begin
            case (op)
                OP: begin
                    ops = instText'({rdName, ",", rs1Name, ",", rs2Name});
                    case ({code.rType.funct7, code.rType.funct3})
                        {7'h00, 3'b000}: mnem = "add";
                        {7'h20, 3'b000}: mnem = "sub";
                        {7'h00, 3'b001}: mnem = "sll";
                        {7'h00, 3'b010}: mnem = "slt";
                        {7'h00, 3'b011}: mnem = "sltu";
                        {7'h00, 3'b100}: mnem = "xor";
                        {7'h00, 3'b101}: mnem = "srl";
                        {7'h20, 3'b101}: mnem = "sra";
                        {7'h00, 3'b110}: mnem = "or";
                        {7'h00, 3'b111}: mnem = "and";
                        default:         legal = 1'b0;
                    endcase
                end
                OPIMM: begin
                    ops = instText'({rdName, ",", rs1Name, ",", iHex[23:0], "H"});
                    case (code.iType.funct3)
                        3'b000:  mnem = "addi";
                        3'b010:  mnem = "slti";
                        3'b011:  mnem = "sltiu";
                        3'b100:  mnem = "xori";
                        3'b110:  mnem = "ori";
                        3'b111:  mnem = "andi";
                        3'b001:  begin
                            mnem  = "slli";
                            legal = code.rType.funct7 == 7'h00;
                        end
                        default: begin
                            mnem  = code.rType.funct7[5] ? "srai" : "srli";
                            legal = (code.rType.funct7 & 7'h5f) == 7'h00;
                        end
                    endcase
                end
                LOAD: begin
                    mnem  = "lw";
                    ops   = instText'({rdName, ",", rs1Name, ",", iHex[23:0], "H"});
                    legal = code.iType.funct3 == 3'b010;
                end
                STORE: begin
                    mnem  = "sw";
                    ops   = instText'({rs1Name, ",", rs2Name, ",", sHex[23:0], "H"});
                    legal = code.sType.funct3 == 3'b010;
                end
                BRANCH: begin
                    ops = instText'({rs1Name, ",", rs2Name, ",", bHex[31:0], "H"});
                    case (code.bType.funct3)
                        3'b000:  mnem = "beq";
                        3'b001:  mnem = "bne";
                        3'b100:  mnem = "blt";
                        3'b101:  mnem = "bge";
                        3'b110:  mnem = "bltu";
                        3'b111:  mnem = "bgeu";
                        default: legal = 1'b0;
                    endcase
                end
                JAL: begin
                    mnem = "jal";
                    ops  = instText'({rdName, ",", jHex, "H"});
                end
                JALR: begin
                    mnem  = "jalr";
                    ops   = instText'({rdName, ",", rs1Name, ",", iHex[23:0], "H"});
                    legal = code.iType.funct3 == 3'b000;
                end
                LUI: begin
                    mnem = "lui";
                    ops  = instText'({rdName, ",", uHex[39:0], "H"});
                end
                SYSTEM: begin
                    if (code.iType.funct3[2]) begin
                        ops = instText'({rdName, ",", iHex[23:0], ",", zHex[15:0]});
                    end else begin
                        ops = instText'({rdName, ",", iHex[23:0], ",", rs1Name});
                    end
                    case (code.iType.funct3)
                        3'b001:  mnem = "csrrw";
                        3'b010:  mnem = "csrrs";
                        3'b011:  mnem = "csrrc";
                        3'b101:  mnem = "csrrwi";
                        3'b110:  mnem = "csrrsi";
                        3'b111:  mnem = "csrrci";
                        default: legal = 1'b0;  // Only mret and ecall use 000.
                    endcase
                end
                default: legal = 1'b0;
            endcase
            if (legal) begin
                text = leftJust(joinText(joinText(mnem, " "), ops));
            end else begin
                text = "illegal instruction";
            end
        end
    end

endmodule

//--- traceLinePkg.sv
`include "trace_consts.svh"

package traceLinePkg;

    // One retired instruction as seen at the core boundary.
    typedef struct packed {
        logic [31:0]         pc;
        rvIsaPkg::rvInstWord code;
    } retireRec;

    // Complete text line, first character in the top byte.
    typedef logic [`LINE_CHARS*8-1:0] traceLine;

endpackage

//--- rvIsaPkg.sv
`include "trace_consts.svh"

package rvIsaPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvRType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvIType;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } rvSType;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rvBType;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvUType;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvJType;

    typedef union packed {
        rvRType rType;
        rvIType iType;
        rvSType sType;
        rvBType bType;
        rvUType uType;
        rvJType jType;
    } rvInstWord;

    // Major opcodes, instruction bits 6:2.
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        OPIMM  = 5'b00100,
        STORE  = 5'b01000,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011,
        SYSTEM = 5'b11100
    } rvOpcode;

    typedef logic [7:0]                asciiChar;
    typedef logic [3*8-1:0]            regText;   // "x" and two hex digits.
    typedef logic [`INST_CHARS*8-1:0]  instText;  // First character in the top byte.

    function automatic asciiChar hexChar(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};  // Uppercase A to F.
    endfunction

endpackage

//--- trace_consts.svh
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Geometry of one retirement trace line.
`define PC_CHARS    8    // Hex digits of the PC.
`define INST_CHARS  19   // Disassembly field width.

// PC digits, ": ", disassembly field and the newline.
`define LINE_CHARS  30

// Saturating counter of retires lost while a line is going out.
`define DROP_BITS   16

`endif
